// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := board_top_tb
FLIST := board_top.f
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: board_top.f
logic/soc_pkg.sv
logic/rst_sync.sv
logic/wb_interconnect.sv
logic/wb_ram.sv
logic/gpio_regs.sv
logic/board_top.sv
verif/board_top_chk.sv
verif/board_top_tb.sv

// File: logic/board_top.sv
// Board-level subsystem top
`timescale 1ns/1ns
`default_nettype none

module board_top import soc_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_pll_locked,
  // Master 0
  input  logic  i_m0_cyc,
  input  logic  i_m0_stb,
  input  logic  i_m0_we,
  input  addr_t i_m0_adr,
  input  word_t i_m0_dat_w,
  output logic  o_m0_ack,
  output word_t o_m0_dat_r,
  // Master 1
  input  logic  i_m1_cyc,
  input  logic  i_m1_stb,
  input  logic  i_m1_we,
  input  addr_t i_m1_adr,
  input  word_t i_m1_dat_w,
  output logic  o_m1_ack,
  output word_t o_m1_dat_r,
  // Pins
  input  gpio_t i_gpio,
  output gpio_t o_gpio,
  output gpio_t o_gpio_dir
);

  logic  w_rst_n;
  logic  w_s_we;
  addr_t w_s_adr;
  word_t w_s_dat_w;
  logic  w_ram_stb;
  logic  w_ram_ack;
  word_t w_ram_dat_r;
  logic  w_gpio_stb;
  logic  w_gpio_ack;
  word_t w_gpio_dat_r;

  // Reset held until PLL lock
  rst_sync rst0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pll_locked (i_pll_locked),
    .o_rst_n      (w_rst_n)
  );

  wb_interconnect xbar0 (
    .i_clk        (i_clk),
    .i_rst_n      (w_rst_n),
    .i_m0_cyc     (i_m0_cyc),
    .i_m0_stb     (i_m0_stb),
    .i_m0_we      (i_m0_we),
    .i_m0_adr     (i_m0_adr),
    .i_m0_dat_w   (i_m0_dat_w),
    .o_m0_ack     (o_m0_ack),
    .o_m0_dat_r   (o_m0_dat_r),
    .i_m1_cyc     (i_m1_cyc),
    .i_m1_stb     (i_m1_stb),
    .i_m1_we      (i_m1_we),
    .i_m1_adr     (i_m1_adr),
    .i_m1_dat_w   (i_m1_dat_w),
    .o_m1_ack     (o_m1_ack),
    .o_m1_dat_r   (o_m1_dat_r),
    .o_s_we       (w_s_we),
    .o_s_adr      (w_s_adr),
    .o_s_dat_w    (w_s_dat_w),
    .o_ram_stb    (w_ram_stb),
    .o_gpio_stb   (w_gpio_stb),
    .i_ram_ack    (w_ram_ack),
    .i_ram_dat_r  (w_ram_dat_r),
    .i_gpio_ack   (w_gpio_ack),
    .i_gpio_dat_r (w_gpio_dat_r)
  );

  // Stands in for the external DDR
  wb_ram ram0 (
    .i_clk   (i_clk),
    .i_rst_n (w_rst_n),
    .i_stb   (w_ram_stb),
    .i_we    (w_s_we),
    .i_adr   (w_s_adr),
    .i_dat_w (w_s_dat_w),
    .o_ack   (w_ram_ack),
    .o_dat_r (w_ram_dat_r)
  );

  gpio_regs gpio0 (
    .i_clk      (i_clk),
    .i_rst_n    (w_rst_n),
    .i_stb      (w_gpio_stb),
    .i_we       (w_s_we),
    .i_adr      (w_s_adr),
    .i_dat_w    (w_s_dat_w),
    .o_ack      (w_gpio_ack),
    .o_dat_r    (w_gpio_dat_r),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir)
  );

endmodule

`default_nettype wire

// File: logic/gpio_regs.sv
// GPIO register slave
`timescale 1ns/1ns
`default_nettype none

module gpio_regs import soc_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_stb,
  input  logic  i_we,
  input  addr_t i_adr,
  input  word_t i_dat_w,
  output logic  o_ack,
  output word_t o_dat_r,
  input  gpio_t i_gpio,
  output gpio_t o_gpio,
  output gpio_t o_gpio_dir
);

  gpio_reg_t w_reg;
  logic      w_access;
  logic      w_commit;
  gpio_t     in_meta_q;
  gpio_t     in_sync_q;

  assign w_reg    = gpio_reg_t'(i_adr[1:0]);
  assign w_access = i_stb & ~o_ack;
  // Writes land at the end of the ack cycle
  assign w_commit = i_stb & o_ack & i_we;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ack      <= 1'b0;
      o_gpio     <= '0;
      o_gpio_dir <= '0;
      in_meta_q  <= '0;
      in_sync_q  <= '0;
    end else begin
      o_ack     <= w_access;
      in_meta_q <= i_gpio;
      in_sync_q <= in_meta_q;
      if (w_commit && w_reg == GPIO_DIR) begin
        o_gpio_dir <= i_dat_w[GPIO_W-1:0];
      end
      if (w_commit && w_reg == GPIO_OUT) begin
        o_gpio <= i_dat_w[GPIO_W-1:0];
      end
    end
  end

  // Read data with the upper bits zero
  always_ff @(posedge i_clk) begin
    if (w_access) begin
      case (w_reg)
        GPIO_DIR: o_dat_r <= {{(DATA_W-GPIO_W){1'b0}}, o_gpio_dir};
        GPIO_OUT: o_dat_r <= {{(DATA_W-GPIO_W){1'b0}}, o_gpio};
        GPIO_IN:  o_dat_r <= {{(DATA_W-GPIO_W){1'b0}}, in_sync_q};
        default:  o_dat_r <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/rst_sync.sv
// Reset and PLL lock synchroniser
`timescale 1ns/1ns
`default_nettype none

module rst_sync (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_pll_locked,
  output logic o_rst_n
);

  logic w_arst_n;
  logic meta_q;
  logic sync_q;

  // Either a low reset or a lost lock holds the subsystem in reset
  assign w_arst_n = i_rst_n & i_pll_locked;

  // Assert at once, release on the second clock edge
  always_ff @(posedge i_clk or negedge w_arst_n) begin
    if (!w_arst_n) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
    end else begin
      meta_q <= 1'b1;
      sync_q <= meta_q;
    end
  end

  assign o_rst_n = sync_q;

endmodule

`default_nettype wire

// File: logic/soc_pkg.sv
// Subsystem bus definitions
`default_nettype none

package soc_pkg;

  // Bus and pin sizes
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int GPIO_W = 12;

  // On-chip memory index width and depth
  localparam int RAM_AW = 8;
  localparam int RAM_WORDS = 1 << RAM_AW;

  // Bit 11 clear selects memory and set selects GPIO
  localparam int SEL_GPIO_BIT = 11;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [GPIO_W-1:0] gpio_t;

  // Arbiter ownership of the shared bus
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_M0,
    ARB_M1
  } arb_state_t;

  // GPIO register selector from the low address bits
  typedef enum logic [1:0] {
    GPIO_DIR  = 2'd0,
    GPIO_OUT  = 2'd1,
    GPIO_IN   = 2'd2,
    GPIO_RSVD = 2'd3
  } gpio_reg_t;

endpackage

`default_nettype wire

// File: logic/wb_interconnect.sv
// Two-master Wishbone interconnect
`timescale 1ns/1ns
`default_nettype none

module wb_interconnect import soc_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  // Master 0
  input  logic  i_m0_cyc,
  input  logic  i_m0_stb,
  input  logic  i_m0_we,
  input  addr_t i_m0_adr,
  input  word_t i_m0_dat_w,
  output logic  o_m0_ack,
  output word_t o_m0_dat_r,
  // Master 1
  input  logic  i_m1_cyc,
  input  logic  i_m1_stb,
  input  logic  i_m1_we,
  input  addr_t i_m1_adr,
  input  word_t i_m1_dat_w,
  output logic  o_m1_ack,
  output word_t o_m1_dat_r,
  // Shared slave bus
  output logic  o_s_we,
  output addr_t o_s_adr,
  output word_t o_s_dat_w,
  output logic  o_ram_stb,
  output logic  o_gpio_stb,
  input  logic  i_ram_ack,
  input  word_t i_ram_dat_r,
  input  logic  i_gpio_ack,
  input  word_t i_gpio_dat_r
);

  arb_state_t state_q;
  arb_state_t state_d;
  logic       last_m1_q;
  logic       w_req0;
  logic       w_req1;
  logic       w_own_req;
  logic       w_sel_gpio;
  logic       w_slv_ack;
  word_t      w_slv_dat;

  assign w_req0 = i_m0_cyc & i_m0_stb;
  assign w_req1 = i_m1_cyc & i_m1_stb;

  // On a tie the master not served last wins
  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (w_req0 && w_req1) begin
          state_d = last_m1_q ? ARB_M0 : ARB_M1;
        end else if (w_req0) begin
          state_d = ARB_M0;
        end else if (w_req1) begin
          state_d = ARB_M1;
        end
      end
      ARB_M0, ARB_M1: begin
        // Grant ends with the owner's ack cycle
        if (w_slv_ack) begin
          state_d = ARB_IDLE;
        end
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= ARB_IDLE;
      last_m1_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == ARB_IDLE && state_d == ARB_M0) begin
        last_m1_q <= 1'b0;
      end else if (state_q == ARB_IDLE && state_d == ARB_M1) begin
        last_m1_q <= 1'b1;
      end
    end
  end

  // Granted request onto the shared bus
  assign o_s_we    = (state_q == ARB_M1) ? i_m1_we    : i_m0_we;
  assign o_s_adr   = (state_q == ARB_M1) ? i_m1_adr   : i_m0_adr;
  assign o_s_dat_w = (state_q == ARB_M1) ? i_m1_dat_w : i_m0_dat_w;

  assign w_own_req = ((state_q == ARB_M0) & w_req0) | ((state_q == ARB_M1) & w_req1);

  // Slave decode on the granted address
  assign w_sel_gpio = o_s_adr[SEL_GPIO_BIT];
  assign o_ram_stb  = w_own_req & ~w_sel_gpio;
  assign o_gpio_stb = w_own_req & w_sel_gpio;

  assign w_slv_ack = w_sel_gpio ? i_gpio_ack : i_ram_ack;
  assign w_slv_dat = w_sel_gpio ? i_gpio_dat_r : i_ram_dat_r;

  // Response goes back to the owner only
  assign o_m0_ack   = (state_q == ARB_M0) & w_slv_ack;
  assign o_m1_ack   = (state_q == ARB_M1) & w_slv_ack;
  assign o_m0_dat_r = (state_q == ARB_M0) ? w_slv_dat : '0;
  assign o_m1_dat_r = (state_q == ARB_M1) ? w_slv_dat : '0;

endmodule

`default_nettype wire

// File: logic/wb_ram.sv
// Single-port word memory slave
`timescale 1ns/1ns
`default_nettype none

module wb_ram import soc_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_stb,
  input  logic  i_we,
  input  addr_t i_adr,
  input  word_t i_dat_w,
  output logic  o_ack,
  output word_t o_dat_r
);

  word_t             mem [RAM_WORDS];
  logic [RAM_AW-1:0] w_idx;
  logic              w_access;

  assign w_idx = i_adr[RAM_AW-1:0];

  // The strobe stays high through the ack cycle, so skip it there
  assign w_access = i_stb & ~o_ack;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= w_access;
    end
  end

  // Array and read data
  always_ff @(posedge i_clk) begin
    if (w_access) begin
      if (i_we) begin
        mem[w_idx] <= i_dat_w;
      end else begin
        o_dat_r <= mem[w_idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/board_top_chk.sv
// Interconnect bus checker
`timescale 1ns/1ns
`default_nettype none

module board_top_chk (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_m0_cyc,
  input logic i_m0_stb,
  input logic i_m1_cyc,
  input logic i_m1_stb,
  input logic i_m0_ack,
  input logic i_m1_ack,
  input logic i_ram_stb,
  input logic i_gpio_stb
);

  int unsigned err_count = 0;

  // Only the owner gets an answer
  one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_m0_ack && i_m1_ack))
    else begin
      $error("Both master acks high in one cycle");
      err_count++;
    end

  // Address decode picks a single slave
  one_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_ram_stb && i_gpio_stb))
    else begin
      $error("Memory and GPIO strobes high together");
      err_count++;
    end

  m0_ack_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_m0_ack |-> (i_m0_cyc && i_m0_stb))
    else begin
      $error("Master 0 acked without a request");
      err_count++;
    end

  m1_ack_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_m1_ack |-> (i_m1_cyc && i_m1_stb))
    else begin
      $error("Master 1 acked without a request");
      err_count++;
    end

endmodule

`default_nettype wire

// File: verif/board_top_tb.sv
// Subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module board_top_tb import soc_pkg::*; ();

  localparam int N_RAND  = 150;
  localparam int TIMEOUT = 50;

  logic  clk;
  logic  rst_n;
  logic  pll_locked;
  logic  req   [2];
  logic  we    [2];
  addr_t adr   [2];
  word_t dat_w [2];
  logic  m0_ack;
  logic  m1_ack;
  word_t m0_dat_r;
  word_t m1_dat_r;
  gpio_t gpio_in;
  gpio_t o_gpio;
  gpio_t o_gpio_dir;

  int    seed = 32'h6785b66d;

  // Reference model
  word_t mem_model [RAM_WORDS];
  gpio_t dir_model;
  gpio_t out_model;

  // Pre-generated random traffic per master
  logic  st_we  [2][N_RAND];
  addr_t st_adr [2][N_RAND];
  word_t st_dat [2][N_RAND];

  // Ack order tracking
  logic  alt_on;
  int    last_owner;
  int    ack_cnt [2];

  board_top uut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_pll_locked (pll_locked),
    .i_m0_cyc     (req[0]),
    .i_m0_stb     (req[0]),
    .i_m0_we      (we[0]),
    .i_m0_adr     (adr[0]),
    .i_m0_dat_w   (dat_w[0]),
    .o_m0_ack     (m0_ack),
    .o_m0_dat_r   (m0_dat_r),
    .i_m1_cyc     (req[1]),
    .i_m1_stb     (req[1]),
    .i_m1_we      (we[1]),
    .i_m1_adr     (adr[1]),
    .i_m1_dat_w   (dat_w[1]),
    .o_m1_ack     (m1_ack),
    .o_m1_dat_r   (m1_dat_r),
    .i_gpio       (gpio_in),
    .o_gpio       (o_gpio),
    .o_gpio_dir   (o_gpio_dir)
  );

  bind wb_interconnect board_top_chk chk0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_m0_cyc   (i_m0_cyc),
    .i_m0_stb   (i_m0_stb),
    .i_m1_cyc   (i_m1_cyc),
    .i_m1_stb   (i_m1_stb),
    .i_m0_ack   (o_m0_ack),
    .i_m1_ack   (o_m1_ack),
    .i_ram_stb  (o_ram_stb),
    .i_gpio_stb (o_gpio_stb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic addr_t gpio_addr(input gpio_reg_t r);
    return {1'b1, 9'd0, r};
  endfunction

  function automatic word_t pad_gpio(input gpio_t v);
    return {{(DATA_W-GPIO_W){1'b0}}, v};
  endfunction

  // Fill value built from every address bit
  function automatic word_t fill_word(input addr_t a);
    return {a, ~a, a[7:0]};
  endfunction

  // One Wishbone classic transfer started 1 ns after a rising edge
  task automatic bus_xfer(input int m, input logic wr, input addr_t a,
                          input word_t wd, output word_t rd);
    int waited;
    waited = 0;
    req[m]   = 1'b1;
    we[m]    = wr;
    adr[m]   = a;
    dat_w[m] = wd;
    @(negedge clk);
    while (!((m == 0) ? m0_ack : m1_ack)) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("Master %0d hung with no ack after %0d cycles", m, TIMEOUT);
        abort_run();
      end
      @(negedge clk);
    end
    rd = (m == 0) ? m0_dat_r : m1_dat_r;
    // Memory model follows ack order
    if (!a[SEL_GPIO_BIT]) begin
      if (wr) begin
        mem_model[a[RAM_AW-1:0]] = wd;
      end else begin
        check_word(rd, mem_model[a[RAM_AW-1:0]], $sformatf("master %0d memory read", m));
      end
    end
    @(posedge clk);
    #1;
    req[m] = 1'b0;
  endtask

  task automatic run_master(input int m);
    word_t rd;
    for (int i = 0; i < N_RAND; i++) begin
      bus_xfer(m, st_we[m][i], st_adr[m][i], st_dat[m][i], rd);
    end
  endtask

  task automatic gpio_write(input gpio_reg_t r, input gpio_t v);
    word_t rd;
    bus_xfer(0, 1'b1, gpio_addr(r), pad_gpio(v), rd);
    if (r == GPIO_DIR) begin
      dir_model = v;
    end
    if (r == GPIO_OUT) begin
      out_model = v;
    end
    // Registers took the value at the end of the ack cycle
    check_gpio(o_gpio_dir, dir_model, "o_gpio_dir after write");
    check_gpio(o_gpio, out_model, "o_gpio after write");
  endtask

  task automatic gpio_read(input gpio_reg_t r, input gpio_t exp);
    word_t rd;
    bus_xfer(0, 1'b0, gpio_addr(r), '0, rd);
    check_word(rd, pad_gpio(exp), $sformatf("GPIO read of %s", r.name()));
  endtask

  // Acks must alternate while both masters keep requesting
  always @(negedge clk) begin
    if (uut.xbar0.chk0.err_count != 0) begin
      $display("The bus checker reported an assertion failure");
      abort_run();
    end
    if (alt_on && (m0_ack || m1_ack)) begin
      if ((m0_ack ? 0 : 1) == last_owner) begin
        $display("Master %0d was acked twice in a row under contention", last_owner);
        abort_run();
      end
      last_owner = m0_ack ? 0 : 1;
      ack_cnt[last_owner]++;
    end
  end

  initial begin
    word_t r;
    word_t rd;
    rst_n      = 1'b0;
    pll_locked = 1'b1;
    gpio_in    = '0;
    alt_on     = 1'b0;
    last_owner = -1;
    ack_cnt[0] = 0;
    ack_cnt[1] = 0;
    dir_model  = '0;
    out_model  = '0;
    for (int m = 0; m < 2; m++) begin
      req[m]   = 1'b0;
      we[m]    = 1'b0;
      adr[m]   = '0;
      dat_w[m] = '0;
    end
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < N_RAND; i++) begin
        r = $random(seed);
        st_we[m][i]  = r[31];
        st_adr[m][i] = {1'b0, r[10:0]};
        st_dat[m][i] = $random(seed);
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    check_gpio(o_gpio, '0, "o_gpio after reset");
    check_gpio(o_gpio_dir, '0, "o_gpio_dir after reset");

    // Known memory contents first
    for (int i = 0; i < RAM_WORDS; i++) begin
      bus_xfer(0, 1'b1, addr_t'(i), fill_word(addr_t'(i)), rd);
    end

    // Random memory traffic from both masters at once
    alt_on = 1'b1;
    fork
      run_master(0);
      run_master(1);
    join
    alt_on = 1'b0;
    if (ack_cnt[0] != N_RAND || ack_cnt[1] != N_RAND) begin
      $display("Ack counts %0d and %0d do not match %0d requests per master",
               ack_cnt[0], ack_cnt[1], N_RAND);
      abort_run();
    end

    // GPIO direction and output registers
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      gpio_write(GPIO_DIR, r[GPIO_W-1:0]);
      gpio_write(GPIO_OUT, r[GPIO_W+15:16]);
      gpio_read(GPIO_DIR, dir_model);
      gpio_read(GPIO_OUT, out_model);
    end

    // Pin inputs through the synchroniser
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      gpio_in = r[GPIO_W-1:0];
      repeat (3) @(posedge clk);
      #1;
      gpio_read(GPIO_IN, gpio_in);
    end
    gpio_read(GPIO_RSVD, '0);
    gpio_write(GPIO_RSVD, 12'hfff);
    gpio_read(GPIO_DIR, dir_model);
    gpio_read(GPIO_OUT, out_model);
    gpio_write(GPIO_DIR, 12'ha5c);
    gpio_write(GPIO_OUT, 12'h3c9);

    // Lost lock holds everything in reset
    pll_locked = 1'b0;
    dir_model  = '0;
    out_model  = '0;
    fork
      bus_xfer(1, 1'b0, st_adr[1][0], '0, rd);
      begin
        repeat (10) begin
          @(negedge clk);
          if (m0_ack || m1_ack) begin
            $display("An ack arrived while the PLL was unlocked");
            abort_run();
          end
          check_gpio(o_gpio, out_model, "o_gpio while unlocked");
          check_gpio(o_gpio_dir, dir_model, "o_gpio_dir while unlocked");
        end
        @(posedge clk);
        #1;
        pll_locked = 1'b1;
      end
    join

    if (uut.xbar0.chk0.err_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("The bus checker reported assertion failures");
      abort_run();
    end
  end

endmodule

`default_nettype wire
